// File: design/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;      // Data word or byte address
    typedef logic [4:0]  regIdxT;    // Register number
    typedef logic [5:0]  opcodeT;    // Instr[31:26]
    typedef logic [5:0]  functT;     // Instr[5:0], R-type only

    localparam opcodeT OpRType = 6'b000000;  // add, sub, and, or, slt
    localparam opcodeT OpAddi  = 6'b001000;  // Immediate add
    localparam opcodeT OpLw    = 6'b100011;  // Load word
    localparam opcodeT OpSw    = 6'b101011;  // Store word
    localparam opcodeT OpBeq   = 6'b000100;  // Branch on equal
    localparam opcodeT OpBne   = 6'b000101;  // Branch on not equal
    localparam opcodeT OpJ     = 6'b000010;  // Absolute jump in 256 MB region

    // Bit 2 set means b is inverted and carry in is one
    typedef enum logic [2:0] {
        AluAnd = 3'b000,      // Bitwise and
        AluOr  = 3'b001,      // Bitwise or
        AluAdd = 3'b010,      // a + b
        AluSub = 3'b110,      // a + ~b + 1
        AluSlt = 3'b111       // Signed a < b
    } aluOpE;

    typedef struct packed {
        logic  aluSrc;        // ALU b from immediate
        logic  regDst;        // Write rd instead of rt
        logic  memWrite;      // Store
        logic  memRead;       // Load
        logic  beq;           // Branch if zero
        logic  bne;           // Branch if not zero
        logic  jump;          // Jump target overrides
        logic  memToReg;      // Writeback from load data
        logic  regWrite;      // Register file write enable
        aluOpE aluOp;         // ALU operation
    } ctrlS;

    typedef struct packed {
        logic write;          // One for store, zero for load
        wordT addr;           // Byte address from ALU
        wordT wdata;          // Store data, rt contents
    } memReqS;

endpackage

// File: design/claBlock.sv
`timescale 1ns/1ps

module claBlock (
    input  logic [3:0] g,
    input  logic [3:0] p,
    input  logic       cin,
    output logic [3:0] carries,   // Carry out of each bit
    output logic       groupG,
    output logic       groupP
);

    // Two-level lookahead, no ripple inside the group
    assign carries[0] = g[0] | (p[0] & cin);
    assign carries[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign carries[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                      | (p[2] & p[1] & p[0] & cin);
    assign carries[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                      | (p[3] & p[2] & p[1] & g[0])
                      | (p[3] & p[2] & p[1] & p[0] & cin);

    assign groupG = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                  | (p[3] & p[2] & p[1] & g[0]);      // Group makes a carry
    assign groupP = &p;                              // Group passes cin

endmodule

// File: design/aluCla.sv
`timescale 1ns/1ps

module aluCla import cpuPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpE op,
    output wordT  result,
    output logic  zero
);

    wordT       bIn;        // b or ~b for subtract and slt
    wordT       gen;        // Per-bit generate
    wordT       prop;       // Per-bit propagate
    wordT       carryIn;    // Carry into each bit
    wordT       carryOut;   // Carry out of each bit, from the groups
    wordT       sum;
    logic [7:0] groupG;
    logic [7:0] groupP;
    logic [8:0] groupCin;   // Ripple between groups, [8] is final carry
    logic       overflow;
    logic       less;       // Signed a < b

    assign bIn  = op[2] ? ~b : b;
    assign gen  = a & bIn;
    assign prop = a | bIn;
    assign groupCin[0] = op[2];        // +1 completes two's complement

    for (genvar k = 0; k < 8; k++) begin : genGroup
        claBlock claBlock_inst (
            .g       (gen[4*k +: 4]),
            .p       (prop[4*k +: 4]),
            .cin     (groupCin[k]),
            .carries (carryOut[4*k +: 4]),
            .groupG  (groupG[k]),
            .groupP  (groupP[k])
        );
        assign groupCin[k+1]    = groupG[k] | (groupP[k] & groupCin[k]);
        assign carryIn[4*k +: 4] = {carryOut[4*k +: 3], groupCin[k]};
    end

    assign sum      = a ^ bIn ^ carryIn;
    assign overflow = carryIn[31] ^ groupCin[8];   // Sign carry in vs out
    assign less     = sum[31] ^ overflow;          // Corrected sign of a - b

    always_comb begin
        case (op)
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluSlt:  result = {31'b0, less};
            default: result = sum;                 // Add and sub
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: design/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; #(
    parameter wordT ResetPc = 32'h0000_0000
) (
    input  logic Clk,
    input  logic reset,
    input  wordT instr,
    input  ctrlS ctrl,
    input  logic zero,
    input  logic stall,
    output wordT pc
);

    wordT pcPlus4;        // Sequential successor
    wordT branchOffset;   // Sign-extended imm16 times four
    wordT branchTarget;
    wordT jumpTarget;
    logic takeBranch;
    wordT nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;               // Relative to delay-free PC+4
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00}; // Stays in current region

    // beq on equal operands, bne on different ones
    assign takeBranch = (ctrl.beq & zero) | (ctrl.bne & ~zero);

    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpTarget;       // Jump wins over branch
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= ResetPc;
        end else if (!stall) begin     // Hold during data access
            pc <= nextPc;
        end
    end

endmodule

// File: design/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import cpuPkg::*; (
    input  wordT instr,
    output ctrlS ctrl
);

    localparam functT FnAdd = 6'b100000;
    localparam functT FnSub = 6'b100010;
    localparam functT FnAnd = 6'b100100;
    localparam functT FnOr  = 6'b100101;
    localparam functT FnSlt = 6'b101010;

    opcodeT opcode;
    functT  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl       = '0;            // Undefined codes fall through as no-op
        ctrl.aluOp = AluAdd;
        case (opcode)
            OpRType: begin
                ctrl.regDst   = 1'b1;        // Write rd
                ctrl.regWrite = 1'b1;
                case (funct)
                    FnAdd:   ctrl.aluOp = AluAdd;
                    FnSub:   ctrl.aluOp = AluSub;
                    FnAnd:   ctrl.aluOp = AluAnd;
                    FnOr:    ctrl.aluOp = AluOr;
                    FnSlt:   ctrl.aluOp = AluSlt;
                    default: begin
                        ctrl.regDst   = 1'b0;   // Unknown funct does nothing
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            OpAddi: begin
                ctrl.aluSrc   = 1'b1;        // Like lw minus the memory
                ctrl.regWrite = 1'b1;
            end
            OpLw: begin
                ctrl.aluSrc   = 1'b1;        // Address = rs + imm
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OpBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = AluSub;         // Compare via difference
            end
            OpBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = AluSub;
            end
            OpJ: begin
                ctrl.jump = 1'b1;
            end
            default: ;                       // Undefined opcode is a no-op
        endcase
    end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic Clk,
    input  logic reset,
    input  wordT instr,
    input  ctrlS ctrl,
    input  wordT aluResult,
    input  wordT loadData,
    input  logic stall,
    output wordT rdA,
    output wordT rdB
);

    wordT   regs [32];
    regIdxT rs;
    regIdxT rt;
    regIdxT dest;          // rd for R-type, rt otherwise
    wordT   writeData;

    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign dest      = ctrl.regDst ? instr[15:11] : rt;
    assign writeData = ctrl.memToReg ? loadData : aluResult;

    assign rdA = (rs == '0) ? '0 : regs[rs];   // $zero is hardwired
    assign rdB = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && !stall && dest != '0) begin
            regs[dest] <= writeData;   // Load writes in its Done cycle
        end
    end

endmodule

// File: design/memAccess.sv
`timescale 1ns/1ps

module memAccess import cpuPkg::*; (
    input  logic   Clk,
    input  logic   reset,
    input  ctrlS   ctrl,
    input  wordT   addr,
    input  wordT   wdata,
    output memReqS memReq,
    output logic   memReqValid,
    input  logic   memReqReady,
    input  wordT   memRdata,
    output logic   stall,
    output wordT   loadData
);

    typedef enum logic [1:0] {
        Idle,       // Waiting for lw or sw
        Request,    // Valid up, waiting for ready
        Done        // Retire cycle, stall released
    } stateE;

    stateE state;
    logic  memOp;       // Current instr touches data memory
    logic  handshake;

    assign memOp       = ctrl.memRead | ctrl.memWrite;
    assign memReqValid = (state == Request);
    assign handshake   = memReqValid & memReqReady;

    // Decode cycle already stalls, retire cycle does not
    assign stall = ((state == Idle) && memOp) || (state == Request);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= Idle;
        end else begin
            case (state)
                Idle:    if (memOp) state <= Request;
                Request: if (handshake) state <= Done;
                default: state <= Idle;            // Done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == Idle && memOp) begin
            memReq.write <= ctrl.memWrite;         // Held stable while valid
            memReq.addr  <= addr;
            memReq.wdata <= wdata;
        end
        if (handshake && !memReq.write) begin
            loadData <= memRdata;                  // Sampled at handshake edge
        end
    end

endmodule

// File: design/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; #(
    parameter wordT ResetPc = 32'h0000_0000
) (
    input  logic   Clk,
    input  logic   reset,
    output wordT   imemAddr,
    input  wordT   imemData,
    output memReqS memReq,
    output logic   memReqValid,
    input  logic   memReqReady,
    input  wordT   memRdata
);

    wordT pc;           // Current fetch address
    ctrlS ctrl;         // Decoded controls of current instr
    wordT rdA;          // rs contents
    wordT rdB;          // rt contents
    wordT immExt;       // Sign-extended imm16
    wordT aluB;         // Second ALU operand
    wordT aluResult;
    logic zero;         // ALU result all zero
    logic stall;        // Data access in progress
    wordT loadData;     // Captured load word

    assign imemAddr = pc;                                    // Fetch is combinational
    assign immExt   = {{16{imemData[15]}}, imemData[15:0]};
    assign aluB     = ctrl.aluSrc ? immExt : rdB;            // Imm for addi, lw, sw

    fetchUnit #(
        .ResetPc(ResetPc)
    ) fetchUnit_inst (
        .Clk   (Clk),
        .reset (reset),
        .instr (imemData),
        .ctrl  (ctrl),
        .zero  (zero),
        .stall (stall),
        .pc    (pc)
    );

    controlDecoder controlDecoder_inst (
        .instr (imemData),
        .ctrl  (ctrl)
    );

    registerFile registerFile_inst (
        .Clk       (Clk),
        .reset     (reset),
        .instr     (imemData),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .loadData  (loadData),
        .stall     (stall),
        .rdA       (rdA),
        .rdB       (rdB)
    );

    aluCla aluCla_inst (
        .a      (rdA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    memAccess memAccess_inst (
        .Clk         (Clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .addr        (aluResult),     // Base plus offset
        .wdata       (rdB),           // sw stores rt
        .memReq      (memReq),
        .memReqValid (memReqValid),
        .memReqReady (memReqReady),
        .memRdata    (memRdata),
        .stall       (stall),
        .loadData    (loadData)
    );

endmodule

// File: sim/tbMemModel.sv
`timescale 1ns/1ps

module tbMemModel import cpuPkg::*; #(
    parameter int unsigned Seed = 32'd1
) (
    input  logic   Clk,
    input  logic   reset,
    input  wordT   imemAddr,
    output wordT   imemData,
    input  memReqS memReq,
    input  logic   memReqValid,
    output logic   memReqReady,
    output wordT   memRdata
);

    wordT        imem [64];    // Program words, loaded by the testbench
    wordT        dmem [64];    // Data words, byte address bits [7:2]
    int unsigned waitLeft;     // Cycles of back-pressure still to apply
    logic        handshake;

    assign imemData = imem[imemAddr[7:2]];       // No handshake on fetch
    assign memRdata = dmem[memReq.addr[7:2]];    // Stable while request held

    initial begin
        memReqReady = 1'b0;
        handshake   = 1'b0;
        waitLeft    = $urandom(Seed);            // Seeds this process once
        waitLeft    = 0;
        forever begin
            @(posedge Clk);
            handshake = memReqValid && memReqReady;    // Values before the edge
            if (handshake && memReq.write)
                dmem[memReq.addr[7:2]] = memReq.wdata;
            #1;
            if (reset || !memReqValid) begin
                memReqReady = 1'b0;
                waitLeft    = $urandom % 4;      // Delay for the next request
            end else if (waitLeft == 0) begin
                memReqReady = 1'b1;
            end else begin
                memReqReady = 1'b0;
                waitLeft--;
            end
        end
    end

endmodule

// File: sim/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb import cpuPkg::*; ();

    localparam int          ClkPeriod     = 4;
    localparam int          NumTests      = 6;
    localparam int          CyclesPerTest = 400;
    localparam int unsigned Seed          = 32'h97f0_648b;
    localparam functT       FnAdd         = 6'b100000;
    localparam functT       FnSub         = 6'b100010;
    localparam functT       FnAnd         = 6'b100100;
    localparam functT       FnOr          = 6'b100101;
    localparam functT       FnSlt         = 6'b101010;

    logic   Clk;
    logic   reset;
    wordT   imemAddr;
    wordT   imemData;
    memReqS memReq;
    logic   memReqValid;
    logic   memReqReady;
    wordT   memRdata;

    wordT   prog[$];       // Program of the current test
    wordT   expAddr[$];    // Stores the program must make in order
    wordT   expData[$];
    wordT   gotAddr[$];    // Stores seen on the data port
    wordT   gotData[$];
    logic   reqHeld;       // Valid without ready at last edge
    memReqS heldReq;

    cpuCore #(
        .ResetPc(32'h0000_0000)
    ) cpuCore_inst (
        .Clk         (Clk),
        .reset       (reset),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .memReq      (memReq),
        .memReqValid (memReqValid),
        .memReqReady (memReqReady),
        .memRdata    (memRdata)
    );

    tbMemModel #(
        .Seed(Seed)
    ) memModel_inst (
        .Clk         (Clk),
        .reset       (reset),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .memReq      (memReq),
        .memReqValid (memReqValid),
        .memReqReady (memReqReady),
        .memRdata    (memRdata)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        #(NumTests * CyclesPerTest * ClkPeriod);
        failRun("Timeout, the tests did not finish within the cycle budget");
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT expected);
        if (got !== expected)
            failRun($sformatf("Error at %0t ns: %s is %h, expected %h",
                              $time, name, got, expected));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected)
            failRun($sformatf("Error at %0t ns: %s is %b, expected %b",
                              $time, name, got, expected));
    endtask

    // Request must not move while ready is low
    always @(posedge Clk) begin
        if (reset) begin
            reqHeld = 1'b0;
        end else begin
            if (reqHeld) begin
                checkFlag("memReqValid", memReqValid, 1'b1);
                checkFlag("memReq.write", memReq.write, heldReq.write);
                checkWord("memReq.addr", memReq.addr, heldReq.addr);
                checkWord("memReq.wdata", memReq.wdata, heldReq.wdata);
            end
            if (memReqValid && memReqReady && memReq.write) begin
                gotAddr.push_back(memReq.addr);    // Store completes here
                gotData.push_back(memReq.wdata);
            end
            reqHeld = memReqValid && !memReqReady;
            heldReq = memReq;
        end
    end

    function automatic wordT encodeR(input regIdxT rs, input regIdxT rt, input regIdxT rd,
                                     input functT funct);
        return {OpRType, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic wordT encodeI(input opcodeT op, input regIdxT rs, input regIdxT rt,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encodeJ(input logic [25:0] target);
        return {OpJ, target};                    // Target is a word index
    endfunction

    function automatic wordT fillWord(input logic [5:0] index);
        return 32'hD000_0000 | {24'h0, index, 2'b00};   // Own byte address in low bits
    endfunction

    task automatic emit(input wordT instr);
        prog.push_back(instr);
    endtask

    task automatic expectStore(input wordT addr, input wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic loadMemories();
        for (int i = 0; i < 64; i++) begin
            memModel_inst.imem[i[5:0]] = encodeJ(26'(i));   // Idle words spin in place
            memModel_inst.dmem[i[5:0]] = fillWord(i[5:0]);
        end
        foreach (prog[i])
            memModel_inst.imem[i[5:0]] = prog[i];
    endtask

    task automatic resetCore();
        @(posedge Clk);
        #1;
        reset = 1'b1;
        loadMemories();
        gotAddr.delete();
        gotData.delete();
        repeat (2) @(posedge Clk);
        #1;
        reset = 1'b0;
        checkFlag("memReqValid", memReqValid, 1'b0);
        checkWord("imemAddr", imemAddr, 32'h0000_0000);
    endtask

    task automatic runProgram();
        wordT addr;
        wordT data;
        resetCore();
        while (expAddr.size() > 0) begin
            while (gotAddr.size() == 0)
                @(posedge Clk);
            addr = gotAddr.pop_front();
            data = gotData.pop_front();
            checkWord("memReq.addr", addr, expAddr.pop_front());
            checkWord("memReq.wdata", data, expData.pop_front());
        end
        repeat (10) @(posedge Clk);              // Room for a stray store
        if (gotAddr.size() != 0)
            failRun("The core made a store that the program does not reach");
        prog.delete();
    endtask

    task automatic branchCase(input logic isBne, input regIdxT rs, input regIdxT rt,
                              input wordT valRs, input wordT valRt, input wordT addrBase);
        logic taken;
        taken = isBne ? (valRs != valRt) : (valRs == valRt);
        emit(encodeI(isBne ? OpBne : OpBeq, rs, rt, 16'd1));    // Skips one word
        emit(encodeI(OpSw, 5'd0, rs, addrBase[15:0]));
        emit(encodeI(OpSw, 5'd0, rt, addrBase[15:0] + 16'd4));
        if (!taken)
            expectStore(addrBase, valRs);
        expectStore(addrBase + 32'd4, valRt);
    endtask

    task automatic testReset();
        runProgram();                            // Empty program makes no stores
        checkWord("imemAddr", imemAddr, 32'h0000_0000);
    endtask

    task automatic testArith();
        wordT a;
        wordT b;
        a = 32'd1234;
        b = -32'd300;
        emit(encodeI(OpAddi, 5'd0, 5'd1, 16'd1234));
        emit(encodeI(OpAddi, 5'd0, 5'd2, 16'hFED4));   // -300
        emit(encodeR(5'd1, 5'd2, 5'd3, FnAdd));
        emit(encodeI(OpSw, 5'd0, 5'd3, 16'h0040));
        emit(encodeR(5'd1, 5'd2, 5'd4, FnSub));
        emit(encodeI(OpSw, 5'd0, 5'd4, 16'h0044));
        emit(encodeR(5'd1, 5'd2, 5'd5, FnAnd));
        emit(encodeI(OpSw, 5'd0, 5'd5, 16'h0048));
        emit(encodeR(5'd1, 5'd2, 5'd6, FnOr));
        emit(encodeI(OpSw, 5'd0, 5'd6, 16'h004C));
        emit(encodeR(5'd2, 5'd1, 5'd7, FnSlt));  // Negative below positive
        emit(encodeI(OpSw, 5'd0, 5'd7, 16'h0050));
        emit(encodeR(5'd1, 5'd2, 5'd8, FnSlt));
        emit(encodeI(OpSw, 5'd0, 5'd8, 16'h0054));
        expectStore(32'h40, a + b);
        expectStore(32'h44, a - b);
        expectStore(32'h48, a & b);
        expectStore(32'h4C, a | b);
        expectStore(32'h50, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expectStore(32'h54, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        runProgram();
    endtask

    task automatic testMemory();
        wordT v;
        v = 32'h0000_1357;
        emit(encodeI(OpAddi, 5'd0, 5'd1, 16'h1357));
        emit(encodeI(OpSw, 5'd0, 5'd1, 16'h0060));
        emit(encodeI(OpLw, 5'd0, 5'd9, 16'h0060));
        emit(encodeI(OpSw, 5'd0, 5'd9, 16'h0064));
        emit(encodeR(5'd9, 5'd1, 5'd11, FnAdd)); // Uses load result at once
        emit(encodeI(OpSw, 5'd0, 5'd11, 16'h0068));
        emit(encodeI(OpLw, 5'd0, 5'd10, 16'h0070));
        emit(encodeI(OpSw, 5'd0, 5'd10, 16'h0074));
        expectStore(32'h60, v);
        expectStore(32'h64, v);
        expectStore(32'h68, v + v);
        expectStore(32'h74, fillWord(6'd28));
        runProgram();
    endtask

    task automatic testBranches();
        emit(encodeI(OpAddi, 5'd0, 5'd1, 16'd5));
        emit(encodeI(OpAddi, 5'd0, 5'd2, 16'd5));
        emit(encodeI(OpAddi, 5'd0, 5'd3, 16'd7));
        branchCase(1'b0, 5'd1, 5'd2, 32'd5, 32'd5, 32'h80);
        branchCase(1'b0, 5'd1, 5'd3, 32'd5, 32'd7, 32'h88);
        branchCase(1'b1, 5'd1, 5'd3, 32'd5, 32'd7, 32'h90);
        branchCase(1'b1, 5'd1, 5'd2, 32'd5, 32'd5, 32'h98);
        runProgram();
    endtask

    task automatic testJump();
        emit(encodeI(OpAddi, 5'd0, 5'd1, 16'h0055));
        emit(encodeJ(26'd4));                    // Over the next two stores
        emit(encodeI(OpSw, 5'd0, 5'd1, 16'h00A0));
        emit(encodeI(OpSw, 5'd0, 5'd1, 16'h00A4));
        emit(encodeI(OpSw, 5'd0, 5'd1, 16'h00A8));
        expectStore(32'hA8, 32'h0000_0055);
        runProgram();
    endtask

    task automatic testRegZero();
        emit(encodeI(OpAddi, 5'd0, 5'd1, 16'd3));
        emit(encodeI(OpAddi, 5'd0, 5'd0, 16'd99));
        emit(encodeR(5'd1, 5'd1, 5'd0, FnAdd));
        emit(encodeI(OpSw, 5'd0, 5'd0, 16'h00B0));
        emit(encodeI(OpLw, 5'd0, 5'd0, 16'h0070));   // Load into r0 dropped too
        emit(encodeI(OpSw, 5'd0, 5'd0, 16'h00B4));
        expectStore(32'hB0, 32'h0000_0000);
        expectStore(32'hB4, 32'h0000_0000);
        runProgram();
    endtask

    initial begin
        reset = 1'b1;
        loadMemories();                          // Defined fetch data from time zero
        testReset();
        testArith();
        testMemory();
        testBranches();
        testJump();
        testRegZero();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
design/cpuPkg.sv
design/claBlock.sv
design/aluCla.sv
design/fetchUnit.sv
design/controlDecoder.sv
design/registerFile.sv
design/memAccess.sv
design/cpuCore.sv
sim/tbMemModel.sv
sim/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module cpuCoreTb -o cpuCoreSim \
    && ./obj_dir/cpuCoreSim | tee sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
